//--- hdl/reorder_consts.svh
`ifndef REORDER_CONSTS_SVH
`define REORDER_CONSTS_SVH

// Lane count of the receive path, 20 in the full PCS
`define REORDER_N_LANES 4

// Width of a logical lane ID
`define REORDER_NB_ID ($clog2(`REORDER_N_LANES))

// 64b/66b block
`define REORDER_NB_BLOCK 66

// Tag bit plus block, as stored in the lane FIFOs
`define REORDER_NB_WORD 67

`endif

//--- hdl/reorder_pkg.sv
package reorder_pkg;

`include "reorder_consts.svh"

    typedef logic [`REORDER_NB_ID-1:0] lane_id_t;

    // One lane FIFO word, tag in the MSB
    typedef struct packed
    {
        logic                          tag;
        logic [`REORDER_NB_BLOCK-1:0]  block;
    } fifo_word_t;

    // Indexed by physical lane
    typedef fifo_word_t [`REORDER_N_LANES-1:0] lane_bundle_t;

    // Recognised logical ID per physical lane
    typedef lane_id_t [`REORDER_N_LANES-1:0] id_bundle_t;

    // Indexed by logical lane, holds the physical lane number
    typedef lane_id_t [`REORDER_N_LANES-1:0] lane_select_t;

endpackage

//--- hdl/lane_order_map.sv
`timescale 1ns/1ps

`include "reorder_consts.svh"

module lane_order_map
(
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_enable,
    input  logic                      i_valid,
    input  logic                      i_deskew_done,
    input  logic                      i_restart,
    input  reorder_pkg::id_bundle_t   i_lane_ids,
    output reorder_pkg::lane_select_t o_selector,
    output logic                      o_map_ready,
    output logic                      o_map_error
);

    import reorder_pkg::*;

    logic     searching;
    lane_id_t search_idx;
    logic     miss_seen;
    logic     hit;
    lane_id_t hit_lane;
    logic     last_idx;

    // Look for the physical lane that reports the current logical index
    always_comb
    begin
        hit      = 1'b0;
        hit_lane = '0;
        for (int p = 0; p < `REORDER_N_LANES; p++)
        begin
            if (i_lane_ids[p] == search_idx)
            begin
                hit      = 1'b1;
                hit_lane = lane_id_t'(p);
            end
        end
    end

    assign last_idx = (search_idx == lane_id_t'(`REORDER_N_LANES - 1));

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            searching   <= 1'b0;
            search_idx  <= '0;
            miss_seen   <= 1'b0;
            o_map_ready <= 1'b0;
            o_map_error <= 1'b0;
        end
        else if (i_enable)
        begin
            if (!i_deskew_done || i_restart)
            begin
                searching   <= i_deskew_done; // A restart with deskew lost waits for the edge
                search_idx  <= '0;
                miss_seen   <= 1'b0;
                o_map_ready <= 1'b0;
                o_map_error <= 1'b0;
            end
            else if (searching && i_valid)
            begin
                if (last_idx)
                begin
                    searching   <= 1'b0;
                    o_map_ready <= !miss_seen && hit;
                    o_map_error <= miss_seen || !hit;
                end
                else
                begin
                    search_idx <= search_idx + 1'b1;
                    miss_seen  <= miss_seen || !hit;
                end
            end
        end
    end

    // Payload only, written once per index during the search
    always_ff @(posedge i_clock)
    begin
        if (i_enable && i_deskew_done && !i_restart && searching && i_valid)
        begin
            o_selector[search_idx] <= hit_lane;
        end
    end

    // The serializer reads the selector every cycle while locked
    a_selector_frozen : assert property (@(posedge i_clock) disable iff (i_reset)
        o_map_ready && $past(o_map_ready) |-> $stable(o_selector));

    a_ready_xor_error : assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_map_ready && o_map_error));

endmodule

//--- hdl/lane_serializer.sv
`timescale 1ns/1ps

`include "reorder_consts.svh"

module lane_serializer
(
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_enable,
    input  logic                      i_lock_start,
    input  logic                      i_bundle_load,
    input  reorder_pkg::lane_bundle_t i_bundle,
    input  reorder_pkg::lane_select_t i_selector,
    output reorder_pkg::fifo_word_t   o_word,
    output logic                      o_valid
);

    import reorder_pkg::*;

    lane_bundle_t shadow;
    lane_id_t     emit_idx;
    logic         active;
    logic         last_idx;
    fifo_word_t   next_word;
    logic [$clog2(`REORDER_N_LANES + 2)-1:0] since_load;

    assign last_idx  = (emit_idx == lane_id_t'(`REORDER_N_LANES - 1));
    assign next_word = shadow[i_selector[emit_idx]]; // Logical lane emit_idx

    // Emission control
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            active   <= 1'b0;
            emit_idx <= '0;
        end
        else if (i_enable)
        begin
            if (i_lock_start)
            begin
                active   <= 1'b0;
                emit_idx <= '0;
            end
            else if (i_bundle_load)
            begin
                active   <= 1'b1; // A new bundle restarts emission
                emit_idx <= '0;
            end
            else if (active)
            begin
                if (last_idx)
                begin
                    active <= 1'b0;
                end
                else
                begin
                    emit_idx <= emit_idx + 1'b1;
                end
            end
        end
    end

    // Shadow copy of the bundle being sent
    always_ff @(posedge i_clock)
    begin
        if (i_enable)
        begin
            if (i_lock_start)
            begin
                shadow <= '0;
            end
            else if (i_bundle_load)
            begin
                shadow <= i_bundle;
            end
        end
    end

    // Word held across stalls, valid only after an enabled edge
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_word  <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_enable && active && !i_lock_start;
            if (i_enable && active && !i_lock_start)
            begin
                o_word <= next_word;
            end
        end
    end

    // Enabled edges since the last load, parked at all ones when idle
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            since_load <= '1;
        end
        else if (i_enable)
        begin
            if (i_lock_start)
            begin
                since_load <= '1;
            end
            else if (i_bundle_load)
            begin
                since_load <= '0;
            end
            else if (since_load != '1)
            begin
                since_load <= since_load + 1'b1;
            end
        end
    end

    a_index_range : assert property (@(posedge i_clock) disable iff (i_reset)
        int'(emit_idx) < `REORDER_N_LANES);

    // Valid words only come out of a load's emission window
    a_valid_after_load : assert property (@(posedge i_clock) disable iff (i_reset)
        o_valid |-> int'(since_load) <= `REORDER_N_LANES);

endmodule

//--- hdl/reorder_top.sv
`timescale 1ns/1ps

`include "reorder_consts.svh"

module reorder_top
(
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_restart_order,
    input  logic                          i_enable,
    input  logic                          i_valid,
    input  logic                          i_deskew_done,
    input  reorder_pkg::id_bundle_t       i_lane_ids,
    input  reorder_pkg::lane_bundle_t     i_data,
    output logic [`REORDER_NB_BLOCK-1:0]  o_data,
    output logic                          o_tag,
    output logic                          o_valid,
    output logic                          o_order_locked,
    output logic                          o_order_error
);

    import reorder_pkg::*;

    logic                         deskew_prev;
    logic                         deskew_rise;
    logic                         restart;
    lane_select_t                 selector;
    logic                         map_ready;
    logic                         map_error;
    logic                         ready_prev;
    logic                         lock_start;
    logic                         discard;
    lane_bundle_t                 bundle_q;
    logic                         load_q;
    fifo_word_t                   ser_word;
    logic [`REORDER_NB_WORD-1:0]  ser_bits;

    // Edge detectors, sampled on enabled cycles only
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            deskew_prev <= 1'b0;
            ready_prev  <= 1'b0;
        end
        else if (i_enable)
        begin
            deskew_prev <= i_deskew_done;
            ready_prev  <= map_ready;
        end
    end

    assign deskew_rise = i_deskew_done && !deskew_prev;
    assign restart     = deskew_rise || i_restart_order;
    assign lock_start  = map_ready && !ready_prev;

    // Bundles are dropped until the map locks; a remap also drops them
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            discard <= 1'b1;
        end
        else if (i_enable)
        begin
            if (!i_deskew_done || restart)
            begin
                discard <= 1'b1;
            end
            else if (lock_start)
            begin
                discard <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            load_q <= 1'b0;
        end
        else if (i_enable)
        begin
            load_q <= i_valid && !discard;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_enable && i_valid && !discard)
        begin
            bundle_q <= i_data;
        end
    end

    lane_order_map u_lane_order_map
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (i_enable),
        .i_valid       (i_valid),
        .i_deskew_done (i_deskew_done),
        .i_restart     (restart),
        .i_lane_ids    (i_lane_ids),
        .o_selector    (selector),
        .o_map_ready   (map_ready),
        .o_map_error   (map_error)
    );

    lane_serializer u_lane_serializer
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (i_enable),
        .i_lock_start  (lock_start),
        .i_bundle_load (load_q),
        .i_bundle      (bundle_q),
        .i_selector    (selector),
        .o_word        (ser_word),
        .o_valid       (o_valid)
    );

    assign ser_bits = ser_word;
    assign o_tag    = ser_bits[`REORDER_NB_WORD-1];   // Tag sits above the block
    assign o_data   = ser_bits[`REORDER_NB_BLOCK-1:0];

    assign o_order_locked = map_ready;
    assign o_order_error  = map_error;

endmodule

//--- bench/reorder_tb.sv
`timescale 1ns/1ps

`include "reorder_consts.svh"

module reorder_tb;

    import reorder_pkg::*;

    localparam int N     = `REORDER_N_LANES;
    localparam int LIMIT = 40 * N; // Cycle budget of each wait

    logic                         i_clock;
    logic                         i_reset;
    logic                         i_restart_order;
    logic                         i_enable;
    logic                         i_valid;
    logic                         i_deskew_done;
    id_bundle_t                   i_lane_ids;
    lane_bundle_t                 i_data;
    logic [`REORDER_NB_BLOCK-1:0] o_data;
    logic                         o_tag;
    logic                         o_valid;
    logic                         o_order_locked;
    logic                         o_order_error;

    integer     seed;
    int         errors;
    int         checks;
    int         mon_errors;
    int         mon_checks;
    int         test_count;
    int         failed_tests;
    int         errors_at_start;
    logic       aborted;
    logic       model_on;
    logic       en_prev;
    string      test_name;
    id_bundle_t perm;
    id_bundle_t old_perm;
    fifo_word_t expect_q[$];

    reorder_top u_dut (.*);

    initial
    begin
        i_clock = 1'b0;
        forever
        begin
            #5 i_clock = ~i_clock;
        end
    end

    task automatic step(input logic en);
        i_enable = en;
        @(posedge i_clock);
        #1; // Inputs change 1 ns after the edge
    endtask

    function automatic lane_bundle_t rand_bundle();
        lane_bundle_t b;
        logic [31:0]  r0;
        logic [31:0]  r1;
        logic [31:0]  r2;
        for (int p = 0; p < N; p++)
        begin
            r0 = $random(seed);
            r1 = $random(seed);
            r2 = $random(seed);
            b[p].tag   = r0[31];
            b[p].block = {r0[1:0], r1, r2};
        end
        return b;
    endfunction

    // Fisher-Yates shuffle of the logical IDs over the physical lanes
    task automatic new_permutation(input logic dup);
        lane_id_t tmp;
        int       j;
        for (int p = 0; p < N; p++)
        begin
            perm[p] = lane_id_t'(p);
        end
        for (int p = N - 1; p > 0; p--)
        begin
            j       = $unsigned($random(seed)) % (p + 1);
            tmp     = perm[p];
            perm[p] = perm[j];
            perm[j] = tmp;
        end
        if (dup)
        begin
            perm[0] = perm[1]; // The ID of lane 0 goes missing
        end
        i_lane_ids = perm;
    endtask

    // Expected words of one bundle: logical lane l comes from the lane that reports ID l
    task automatic push_bundle(input lane_bundle_t b);
        for (int l = 0; l < N; l++)
        begin
            for (int p = 0; p < N; p++)
            begin
                if (int'(perm[p]) == l)
                begin
                    expect_q.push_back(b[p]);
                end
            end
        end
    endtask

    // Keeps i_valid up with random data until the map locks or fails
    task automatic wait_map(input logic expect_lock);
        int cycles;
        cycles   = 0;
        model_on = 1'b0;
        i_valid  = 1'b1;
        while (!o_order_locked && !o_order_error && cycles < LIMIT)
        begin
            i_data = rand_bundle();
            step(1'b1);
            cycles++;
        end
        i_valid = 1'b0;
        checks++;
        assert (o_order_locked || o_order_error) else
        begin
            errors++;
            aborted = 1'b1;
            $display("ERROR %s: lane map neither locked nor failed in %0d cycles", test_name, LIMIT);
        end
        checks++;
        assert ({o_order_locked, o_order_error} == {expect_lock, !expect_lock}) else
        begin
            errors++;
            $display("MISMATCH %s: lock/error expected %b%b actual %b%b", test_name,
                     expect_lock, !expect_lock, o_order_locked, o_order_error);
        end
        step(1'b1);
        step(1'b1);
    endtask

    // One bundle per N enabled cycles, taken at the first enabled edge
    task automatic send_bundle(input logic push, input logic stall);
        int   enabled;
        int   cycles;
        logic en;
        enabled  = 0;
        cycles   = 0;
        model_on = push;
        i_data   = rand_bundle();
        i_valid  = 1'b1;
        while (enabled < N && cycles < LIMIT)
        begin
            en = stall ? ($unsigned($random(seed)) % 4 != 0) : 1'b1;
            step(en);
            cycles++;
            if (en)
            begin
                enabled++;
                i_valid  = 1'b0;
                model_on = 1'b0;
            end
        end
        checks++;
        assert (enabled == N) else
        begin
            errors++;
            aborted = 1'b1;
            $display("ERROR %s: only %0d enabled cycles in %0d clocks", test_name, enabled, LIMIT);
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (expect_q.size() > 0 && cycles < LIMIT)
        begin
            step(1'b1);
            cycles++;
        end
        checks++;
        assert (expect_q.size() == 0) else
        begin
            errors++;
            aborted = 1'b1;
            $display("ERROR %s: %0d expected words never came out", test_name, expect_q.size());
        end
        repeat (N + 2) step(1'b1); // Room for stray words to show up
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors + mon_errors;
        test_count++;
    endtask

    task automatic end_test();
        if (errors + mon_errors == errors_at_start)
        begin
            $display("%-18s passed", test_name);
        end
        else
        begin
            failed_tests++;
            $display("%-18s failed, %0d errors", test_name, errors + mon_errors - errors_at_start);
        end
    endtask

    // Checker and model, sampled mid-cycle
    always @(negedge i_clock)
    begin
        fifo_word_t want;
        if (!i_reset && o_valid)
        begin
            mon_checks++;
            assert (en_prev) else
            begin
                mon_errors++;
                $display("ERROR %s: o_valid high after a disabled edge", test_name);
            end
            assert (expect_q.size() > 0) else
            begin
                mon_errors++;
                $display("ERROR %s: valid word with no accepted bundle", test_name);
            end
            if (expect_q.size() > 0)
            begin
                want = expect_q.pop_front();
                assert ({o_tag, o_data} == want) else
                begin
                    mon_errors++;
                    $display("MISMATCH %s: expected %h actual %h", test_name, want, {o_tag, o_data});
                end
            end
        end
        if (!i_reset && i_enable && i_valid && model_on)
        begin
            push_bundle(i_data); // Taken at the coming edge
        end
        en_prev = i_enable;
    end

    initial
    begin
        seed            = 32'h2d6f_a0c1;
        errors          = 0;
        checks          = 0;
        mon_errors      = 0;
        mon_checks      = 0;
        test_count      = 0;
        failed_tests    = 0;
        aborted         = 1'b0;
        model_on        = 1'b0;
        i_reset         = 1'b1;
        i_restart_order = 1'b0;
        i_enable        = 1'b1;
        i_valid         = 1'b0;
        i_deskew_done   = 1'b0;
        i_lane_ids      = '0;
        i_data          = '0;
        repeat (10) @(posedge i_clock);
        #1;
        i_reset = 1'b0;

        begin_test("lock_permutation");
        checks++;
        assert (!o_valid && !o_order_locked && !o_order_error && o_data == '0) else
        begin
            errors++;
            $display("ERROR %s: outputs not cleared by reset", test_name);
        end
        new_permutation(1'b0);
        i_deskew_done = 1'b1;
        wait_map(1'b1);
        end_test();

        if (!aborted)
        begin
            begin_test("reorder_output");
            repeat (30) send_bundle(1'b1, 1'b0);
            drain();
            end_test();
        end

        if (!aborted)
        begin
            begin_test("drop_relock");
            i_deskew_done = 1'b0;
            step(1'b1);
            checks++;
            assert (!o_order_locked) else
            begin
                errors++;
                $display("ERROR %s: lock held after deskew done fell", test_name);
            end
            repeat (3) send_bundle(1'b0, 1'b0);
            old_perm = perm;
            new_permutation(1'b0);
            if (perm == old_perm)
            begin
                perm[0]    = old_perm[1]; // The new map must differ from the old one
                perm[1]    = old_perm[0];
                i_lane_ids = perm;
            end
            i_deskew_done = 1'b1;
            wait_map(1'b1);
            repeat (20) send_bundle(1'b1, 1'b0);
            drain();
            end_test();
        end

        if (!aborted)
        begin
            begin_test("enable_stalls");
            repeat (30) send_bundle(1'b1, 1'b1);
            drain();
            end_test();
        end

        if (!aborted)
        begin
            begin_test("missing_id");
            new_permutation(1'b1);
            i_restart_order = 1'b1;
            step(1'b1);
            i_restart_order = 1'b0;
            wait_map(1'b0);
            repeat (4) send_bundle(1'b0, 1'b0);
            drain();
            end_test();
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors", test_count, failed_tests,
                 checks + mon_checks, errors + mon_errors);
        if (errors + mon_errors == 0 && !aborted)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+hdl
hdl/reorder_pkg.sv
hdl/lane_order_map.sv
hdl/lane_serializer.sv
hdl/reorder_top.sv
bench/reorder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the reorder testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module reorder_tb \
    --Mdir obj_dir -o reorder_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/reorder_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
